/* src/stream_test_pkg.sv */
`default_nettype none

package stream_test_pkg;

	//--------------------------------------------------------------------------
	// Widths with a meaning
	//--------------------------------------------------------------------------
	typedef logic [31:0] word_t;                // One payload word
	typedef logic [15:0] half_t;                // Checksum or packet number half
	typedef logic [15:0] len_t;                 // Payload length in words
	typedef logic [33:0] tx_entry_t;            // Data word above sop above eop

	// Field positions inside a FIFO entry
	localparam int ENTRY_DATA_LSB = 2;
	localparam int ENTRY_SOP_BIT  = 1;
	localparam int ENTRY_EOP_BIT  = 0;

	// Generator FSM
	typedef enum logic [2:0]
	{
		GEN_IDLE,
		GEN_HEAD0,
		GEN_HEAD1,
		GEN_DATA,
		GEN_TRAILER,
		GEN_DRAIN
	} gen_state_t;

	// Protocol head words and test pattern
	localparam word_t       HEAD0         = 32'h5E4D_0B05;
	localparam half_t       HEAD1         = 16'h9FB4;     // Packet number goes below
	localparam word_t       PATTERN_BASE  = 32'h0001_0203;
	localparam logic [7:0]  PATTERN_STEP  = 8'd4;         // Per byte, wraps mod 256
	localparam len_t        MIN_LEN_WORDS = 16'd3;        // Trailer not counted

	// Add both halves of a word to a ones' complement accumulator
	function automatic half_t csum_add(input half_t acc, input word_t w);
		logic [17:0] sum;
		logic [16:0] fold;
		sum  = {2'b00, acc} + {2'b00, w[31:16]} + {2'b00, w[15:0]};
		fold = {1'b0, sum[15:0]} + {15'd0, sum[17:16]};   // First end-around carry
		return fold[15:0] + {15'd0, fold[16]};             // At most one more carry
	endfunction

endpackage

`default_nettype wire

/* src/word_push_if.sv */
`timescale 1ns/100ps
`default_nettype none

// Tagged payload words from the generator into the FIFO
interface word_push_if;
	logic                   valid;  // Store strobe
	stream_test_pkg::word_t data;
	logic                   sop;    // First word of a payload
	logic                   eop;    // Trailer word
	logic                   full;   // FIFO back-pressure

	modport producer
	(
		output valid,
		output data,
		output sop,
		output eop,
		input  full
	);

	modport consumer
	(
		input  valid,
		input  data,
		input  sop,
		input  eop,
		output full
	);
endinterface

`default_nettype wire

/* src/word_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module word_fifo
#(
	parameter int unsigned FIFO_DEPTH = 512
)
(
	input  wire                              pll_62_5m_clk,
	input  wire                              rst_n,
	input  wire                              rd_i,      // Pop the head entry
	output stream_test_pkg::tx_entry_t       q_o,       // Head entry, show-ahead
	output logic                             empty_o,
	word_push_if.consumer                    push
);

	localparam int unsigned AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

	stream_test_pkg::tx_entry_t mem [FIFO_DEPTH];
	logic [AW-1:0]              wr_ptr_q;
	logic [AW-1:0]              rd_ptr_q;
	logic [AW:0]                count_q;      // Occupancy

	// Pointer step with wrap for any depth
	function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
		if (ptr == AW'(FIFO_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	// Storage
	always_ff @(posedge pll_62_5m_clk)
		if (push.valid)
			mem[wr_ptr_q] <= {push.data, push.sop, push.eop};

	always_ff @(posedge pll_62_5m_clk or negedge rst_n)
		if (!rst_n)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end
		else
		begin
			if (push.valid)
				wr_ptr_q <= next_ptr(wr_ptr_q);
			if (rd_i)
				rd_ptr_q <= next_ptr(rd_ptr_q);
			case ({push.valid, rd_i})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;       // Both or neither
			endcase
		end

	assign push.full = (count_q == (AW+1)'(FIFO_DEPTH));
	assign empty_o   = (count_q == '0);
	assign q_o       = mem[rd_ptr_q];

endmodule

`default_nettype wire

/* src/payload_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module payload_gen
(
	input  wire                        pll_62_5m_clk,
	input  wire                        rst_n,
	input  wire                        start_i,
	input  wire stream_test_pkg::len_t payload_len_i,
	input  wire                        tx_done_i,      // Trailer left the framer
	output logic                       busy_o,
	word_push_if.producer              push
);

	stream_test_pkg::gen_state_t state_q;
	stream_test_pkg::gen_state_t state_d;
	logic                        start_q;     // Registered start
	logic                        accept;
	logic                        in_frame;    // A word is ready to push
	logic                        push_ok;
	logic                        last_data;
	stream_test_pkg::len_t       len_q;
	stream_test_pkg::len_t       word_cnt_q;  // Words pushed so far
	stream_test_pkg::word_t      pattern_q;
	stream_test_pkg::half_t      csum_q;      // Running sum over words 0 to N-1
	stream_test_pkg::half_t      pkt_num_q;

	//--------------------------------------------------------------------------
	// Start control
	//--------------------------------------------------------------------------
	assign busy_o = start_q | (state_q != stream_test_pkg::GEN_IDLE);
	assign accept = start_i & ~busy_o &
		(payload_len_i >= stream_test_pkg::MIN_LEN_WORDS);   // Short lengths dropped

	always_ff @(posedge pll_62_5m_clk or negedge rst_n)
		if (!rst_n)
			start_q <= 1'b0;
		else
			start_q <= accept;                // One cycle pulse

	//--------------------------------------------------------------------------
	// Sequencing
	//--------------------------------------------------------------------------
	assign in_frame  = (state_q == stream_test_pkg::GEN_HEAD0) |
		(state_q == stream_test_pkg::GEN_HEAD1) |
		(state_q == stream_test_pkg::GEN_DATA) |
		(state_q == stream_test_pkg::GEN_TRAILER);
	assign push_ok   = in_frame & ~push.full;
	assign last_data = (word_cnt_q == len_q - 16'd1);

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			stream_test_pkg::GEN_IDLE:    if (start_q) state_d = stream_test_pkg::GEN_HEAD0;
			stream_test_pkg::GEN_HEAD0:   if (push_ok) state_d = stream_test_pkg::GEN_HEAD1;
			stream_test_pkg::GEN_HEAD1:   if (push_ok) state_d = stream_test_pkg::GEN_DATA;
			stream_test_pkg::GEN_DATA:
				if (push_ok && last_data)
					state_d = stream_test_pkg::GEN_TRAILER;
			stream_test_pkg::GEN_TRAILER: if (push_ok) state_d = stream_test_pkg::GEN_DRAIN;
			stream_test_pkg::GEN_DRAIN:   if (tx_done_i) state_d = stream_test_pkg::GEN_IDLE;
			default:                      state_d = stream_test_pkg::GEN_IDLE;
		endcase
	end

	always_ff @(posedge pll_62_5m_clk or negedge rst_n)
		if (!rst_n)
		begin
			state_q    <= stream_test_pkg::GEN_IDLE;
			word_cnt_q <= '0;
			pkt_num_q  <= '0;
		end
		else
		begin
			state_q <= state_d;
			if (start_q)
				word_cnt_q <= '0;
			else if (push_ok)
				word_cnt_q <= word_cnt_q + 16'd1;
			if (state_q == stream_test_pkg::GEN_DRAIN && tx_done_i)
				pkt_num_q <= pkt_num_q + 16'd1;   // Counts sent trailers
		end

	// Length, pattern and checksum
	always_ff @(posedge pll_62_5m_clk)
	begin
		if (accept)
			len_q <= payload_len_i;
		if (start_q)
		begin
			pattern_q <= stream_test_pkg::PATTERN_BASE;
			csum_q    <= '0;
		end
		else if (push_ok)
		begin
			if (state_q == stream_test_pkg::GEN_DATA)
				for (int b = 0; b < 4; b++)
					pattern_q[8*b +: 8] <= pattern_q[8*b +: 8] + stream_test_pkg::PATTERN_STEP;
			if (state_q != stream_test_pkg::GEN_TRAILER)
				csum_q <= stream_test_pkg::csum_add(csum_q, push.data);
		end
	end

	//--------------------------------------------------------------------------
	// Word output
	//--------------------------------------------------------------------------
	always_comb
		case (state_q)
			stream_test_pkg::GEN_HEAD0:   push.data = stream_test_pkg::HEAD0;
			stream_test_pkg::GEN_HEAD1:   push.data = {stream_test_pkg::HEAD1, pkt_num_q};
			stream_test_pkg::GEN_TRAILER: push.data = {~csum_q, 16'h0000};
			default:                      push.data = pattern_q;
		endcase

	assign push.valid = push_ok;
	assign push.sop   = (state_q == stream_test_pkg::GEN_HEAD0);
	assign push.eop   = (state_q == stream_test_pkg::GEN_TRAILER);

endmodule

`default_nettype wire

/* src/tx_framer.sv */
`timescale 1ns/100ps
`default_nettype none

module tx_framer
(
	input  wire                              pll_62_5m_clk,
	input  wire                              rst_n,
	input  wire                              tx_wa_i,     // MAC write allowed
	input  wire stream_test_pkg::tx_entry_t  entry_i,     // FIFO head
	input  wire                              empty_i,
	output logic                             rd_o,        // FIFO pop
	output logic                             tx_wr_o,
	output stream_test_pkg::word_t           tx_data_o,
	output logic                             tx_sop_o,
	output logic                             tx_eop_o,
	output logic                             tx_done_o    // Trailer sent
);

	logic wr_en_q;   // Registered write enable
	logic fire;      // A word moves this cycle

	//--------------------------------------------------------------------------
	// Write enable follows write allowed and FIFO contents
	//--------------------------------------------------------------------------
	always_ff @(posedge pll_62_5m_clk or negedge rst_n)
		if (!rst_n)
			wr_en_q <= 1'b0;
		else if (!tx_wa_i || empty_i)
			wr_en_q <= 1'b0;                  // Drop one cycle after wa falls
		else
			wr_en_q <= 1'b1;

	// Enable can be stale by one cycle so gate it with the live flag
	assign fire    = wr_en_q & ~empty_i;
	assign rd_o    = fire;
	assign tx_wr_o = fire;

	// Unpack the entry
	assign tx_data_o = entry_i[stream_test_pkg::ENTRY_DATA_LSB +: $bits(stream_test_pkg::word_t)];
	assign tx_sop_o  = fire & entry_i[stream_test_pkg::ENTRY_SOP_BIT];
	assign tx_eop_o  = fire & entry_i[stream_test_pkg::ENTRY_EOP_BIT];

	// End of packet back to the generator
	assign tx_done_o = tx_eop_o;

endmodule

`default_nettype wire

/* src/rx_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module rx_checker
#(
	parameter int unsigned ACT_HOLD_CYCLES = 125_000_000
)
(
	input  wire                          pll_62_5m_clk,
	input  wire                          rst_n,
	input  wire                          rx_pa_i,        // Valid word strobe
	input  wire stream_test_pkg::word_t  rx_data_i,
	input  wire                          rx_sop_i,
	input  wire                          rx_eop_i,
	output logic                         act_led_o,      // Active low
	output logic                         seq_err_led_o,
	output logic                         chksum_err_led_o
);

	localparam int unsigned TW = $clog2(ACT_HOLD_CYCLES + 1);

	stream_test_pkg::len_t  word_cnt_q;   // Words seen in this packet
	stream_test_pkg::len_t  word_idx;     // Index of the word on the bus
	stream_test_pkg::half_t num_q;        // Latched packet number
	stream_test_pkg::half_t num_seen;
	stream_test_pkg::half_t sum_q;
	stream_test_pkg::half_t sum_d;
	stream_test_pkg::half_t exp_cnt_q;    // Expected packet number
	logic                   rx_end;
	logic                   seq_err_q;
	logic                   chksum_err_q;
	logic                   led_on_q;
	logic [TW-1:0]          led_timer_q;

	//--------------------------------------------------------------------------
	// Packet number and checksum
	//--------------------------------------------------------------------------
	assign word_idx = rx_sop_i ? '0 : word_cnt_q;
	assign sum_d    = stream_test_pkg::csum_add(rx_sop_i ? '0 : sum_q, rx_data_i);
	assign num_seen = (word_idx == 16'd1) ? rx_data_i[15:0] : num_q;
	assign rx_end   = rx_pa_i & rx_eop_i;

	always_ff @(posedge pll_62_5m_clk)
		if (rx_pa_i)
		begin
			sum_q <= sum_d;                   // Restarts at sop
			if (word_idx == 16'd1)
				num_q <= rx_data_i[15:0];     // Low half of word 1
		end

	always_ff @(posedge pll_62_5m_clk or negedge rst_n)
		if (!rst_n)
		begin
			word_cnt_q   <= '0;
			exp_cnt_q    <= '0;
			seq_err_q    <= 1'b0;
			chksum_err_q <= 1'b0;
		end
		else if (rx_pa_i)
		begin
			if (word_idx != '1)
				word_cnt_q <= word_idx + 16'd1;   // Saturates on huge packets
			if (rx_end)
			begin
				exp_cnt_q <= exp_cnt_q + 16'd1;
				if (num_seen != exp_cnt_q)
					seq_err_q <= 1'b1;            // Sticky
				if (sum_d != 16'hFFFF)
					chksum_err_q <= 1'b1;         // Sticky
			end
		end

	//--------------------------------------------------------------------------
	// Activity LED hold timer
	//--------------------------------------------------------------------------
	always_ff @(posedge pll_62_5m_clk or negedge rst_n)
		if (!rst_n)
		begin
			led_timer_q <= '0;
			led_on_q    <= 1'b0;              // Off
		end
		else if (rx_pa_i)
		begin
			led_timer_q <= TW'(ACT_HOLD_CYCLES - 1);
			led_on_q    <= 1'b1;
		end
		else if (led_timer_q != '0)
			led_timer_q <= led_timer_q - 1'b1;
		else
			led_on_q <= 1'b0;                 // Hold time ran out

	// LEDs light on a low level
	assign act_led_o        = ~led_on_q;
	assign seq_err_led_o    = ~seq_err_q;
	assign chksum_err_led_o = ~chksum_err_q;

endmodule

`default_nettype wire

/* src/stream_test_top.sv */
`timescale 1ns/100ps
`default_nettype none

module stream_test_top
#(
	parameter int unsigned FIFO_DEPTH      = 512,
	parameter int unsigned ACT_HOLD_CYCLES = 125_000_000
)
(
	input  wire                          pll_62_5m_clk,
	input  wire                          rst_n,
	// Generator control
	input  wire                          start_i,
	input  wire stream_test_pkg::len_t   payload_len_i,
	output logic                         busy_o,
	// MAC transmit side
	input  wire                          tx_wa_i,
	output logic                         tx_wr_o,
	output stream_test_pkg::word_t       tx_data_o,
	output logic                         tx_sop_o,
	output logic                         tx_eop_o,
	// MAC receive side
	input  wire                          rx_pa_i,
	input  wire stream_test_pkg::word_t  rx_data_i,
	input  wire                          rx_sop_i,
	input  wire                          rx_eop_i,
	// LEDs, active low
	output logic                         act_led_o,
	output logic                         seq_err_led_o,
	output logic                         chksum_err_led_o
);

	logic                       tx_done;      // Trailer went out
	logic                       fifo_rd;
	logic                       fifo_empty;
	stream_test_pkg::tx_entry_t fifo_q;

	word_push_if u_push_if ();

	//--------------------------------------------------------------------------
	// Transmit path
	//--------------------------------------------------------------------------
	payload_gen u_payload_gen
	(
		.pll_62_5m_clk (pll_62_5m_clk),
		.rst_n         (rst_n),
		.start_i       (start_i),
		.payload_len_i (payload_len_i),
		.tx_done_i     (tx_done),
		.busy_o        (busy_o),
		.push          (u_push_if.producer)
	);

	word_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_word_fifo
	(
		.pll_62_5m_clk (pll_62_5m_clk),
		.rst_n         (rst_n),
		.rd_i          (fifo_rd),
		.q_o           (fifo_q),
		.empty_o       (fifo_empty),
		.push          (u_push_if.consumer)
	);

	tx_framer u_tx_framer
	(
		.pll_62_5m_clk (pll_62_5m_clk),
		.rst_n         (rst_n),
		.tx_wa_i       (tx_wa_i),
		.entry_i       (fifo_q),
		.empty_i       (fifo_empty),
		.rd_o          (fifo_rd),
		.tx_wr_o       (tx_wr_o),
		.tx_data_o     (tx_data_o),
		.tx_sop_o      (tx_sop_o),
		.tx_eop_o      (tx_eop_o),
		.tx_done_o     (tx_done)
	);

	// Receive checks and LEDs
	rx_checker #(
		.ACT_HOLD_CYCLES (ACT_HOLD_CYCLES)
	) u_rx_checker
	(
		.pll_62_5m_clk    (pll_62_5m_clk),
		.rst_n            (rst_n),
		.rx_pa_i          (rx_pa_i),
		.rx_data_i        (rx_data_i),
		.rx_sop_i         (rx_sop_i),
		.rx_eop_i         (rx_eop_i),
		.act_led_o        (act_led_o),
		.seq_err_led_o    (seq_err_led_o),
		.chksum_err_led_o (chksum_err_led_o)
	);

endmodule

`default_nettype wire

/* tests/stream_test_properties.sv */
`timescale 1ns/100ps
`default_nettype none

module stream_test_properties
#(
	parameter int unsigned FIFO_DEPTH = 512
)
(
	input wire pll_62_5m_clk,
	input wire rst_n,
	input wire busy_i,
	input wire tx_wr_i,
	input wire tx_sop_i,
	input wire tx_eop_i,
	input wire push_valid_i
);

	int unsigned fail_count = 0;   // Failed assertions so far
	int          occ;              // FIFO entries seen from pushes and pops

	// Shadow occupancy kept apart from the FIFO's own count
	always @(posedge pll_62_5m_clk or negedge rst_n)
		if (!rst_n)
			occ <= 0;
		else
			occ <= occ + int'(push_valid_i) - int'(tx_wr_i);

	// Framer never pops an empty FIFO
	a_wr_not_empty: assert property (@(posedge pll_62_5m_clk) disable iff (!rst_n)
		tx_wr_i |-> (occ > 0))
	else
	begin
		fail_count++;
		$error("tx_wr_o while the FIFO is empty");
	end

	// Frame flags only with the strobe
	a_flags_with_wr: assert property (@(posedge pll_62_5m_clk) disable iff (!rst_n)
		(tx_sop_i || tx_eop_i) |-> tx_wr_i)
	else
	begin
		fail_count++;
		$error("tx_sop_o or tx_eop_o without tx_wr_o");
	end

	a_no_push_full: assert property (@(posedge pll_62_5m_clk) disable iff (!rst_n)
		push_valid_i |-> (occ < int'(FIFO_DEPTH)))
	else
	begin
		fail_count++;
		$error("push into a full FIFO");
	end

	a_idle_after_reset: assert property (@(posedge pll_62_5m_clk) $rose(rst_n) |-> !busy_i)
	else
	begin
		fail_count++;
		$error("busy_o high after reset");
	end

endmodule

bind stream_test_top stream_test_properties #(
	.FIFO_DEPTH (FIFO_DEPTH)
) u_props
(
	.pll_62_5m_clk (pll_62_5m_clk),
	.rst_n         (rst_n),
	.busy_i        (busy_o),
	.tx_wr_i       (tx_wr_o),
	.tx_sop_i      (tx_sop_o),
	.tx_eop_i      (tx_eop_o),
	.push_valid_i  (u_push_if.valid)
);

`default_nettype wire

/* tests/stream_test_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module stream_test_tb;

	localparam int unsigned FIFO_DEPTH      = 8;
	localparam int unsigned ACT_HOLD_CYCLES = 20;
	localparam int unsigned RESET_CYCLES    = 8;
	// Reset, two packets (random write-allowed up to 8 cycles a word), short start,
	// four receive replays with LED hold, then a 4x margin
	localparam int unsigned TIMEOUT_CYCLES  = 4 * (RESET_CYCLES + 3 * (6 + 1) + 8 * (12 + 1)
		+ 12 + 4 * (8 + ACT_HOLD_CYCLES + 4));

	// Payload rules
	localparam logic [31:0] M_HEAD0 = 32'h5E4D_0B05;
	localparam logic [15:0] M_HEAD1 = 16'h9FB4;

	logic                   pll_62_5m_clk;
	logic                   rst_n;
	logic                   start;
	stream_test_pkg::len_t  payload_len;
	logic                   busy;
	logic                   tx_wa;
	logic                   tx_wr;
	stream_test_pkg::word_t tx_data;
	logic                   tx_sop;
	logic                   tx_eop;
	logic                   rx_pa;
	stream_test_pkg::word_t rx_data;
	logic                   rx_sop;
	logic                   rx_eop;
	logic                   act_led;
	logic                   seq_err_led;
	logic                   chksum_err_led;

	logic [33:0]            exp_q[$];      // Model words as {data, sop, eop}
	logic [33:0]            tx_log_q[$];   // Every word the framer sent
	logic [15:0]            lfsr_q = 16'd77;
	int unsigned            cycle_cnt = 0;

	stream_test_top #(
		.FIFO_DEPTH      (FIFO_DEPTH),
		.ACT_HOLD_CYCLES (ACT_HOLD_CYCLES)
	) u_stream_test_top
	(
		.pll_62_5m_clk    (pll_62_5m_clk),
		.rst_n            (rst_n),
		.start_i          (start),
		.payload_len_i    (payload_len),
		.busy_o           (busy),
		.tx_wa_i          (tx_wa),
		.tx_wr_o          (tx_wr),
		.tx_data_o        (tx_data),
		.tx_sop_o         (tx_sop),
		.tx_eop_o         (tx_eop),
		.rx_pa_i          (rx_pa),
		.rx_data_i        (rx_data),
		.rx_sop_i         (rx_sop),
		.rx_eop_i         (rx_eop),
		.act_led_o        (act_led),
		.seq_err_led_o    (seq_err_led),
		.chksum_err_led_o (chksum_err_led)
	);

	always #100 pll_62_5m_clk = ~pll_62_5m_clk;   // 200 ns period

	// Hung run guard
	always @(posedge pll_62_5m_clk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: tests still running after %0d cycles", cycle_cnt);
			$display("TESTBENCH FAILED");
			$fatal(1, "simulation stopped by the cycle limit");
		end
	end

	// Bound assertions end the run at their first failure
	always @(negedge pll_62_5m_clk)
		if (u_stream_test_top.u_props.fail_count != 0)
		begin
			$display("A bound assertion on the design failed");
			$display("TESTBENCH FAILED");
			$fatal(1, "stopping at first assertion failure");
		end

	// Transmit monitor, sampled mid-cycle
	always @(negedge pll_62_5m_clk)
		if (rst_n && tx_wr)
			tx_log_q.push_back({tx_data, tx_sop, tx_eop});

	//--------------------------------------------------------------------------
	// Helpers
	//--------------------------------------------------------------------------
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);   // Galois, x^16+x^14+x^13+x^11+1
	endfunction

	function automatic logic rand_bit();
		lfsr_q = lfsr_step(lfsr_q);
		return lfsr_q[0];
	endfunction

	// Ones' complement add with end-around carry
	function automatic logic [15:0] ones_add(input logic [15:0] a, input logic [15:0] b);
		logic [16:0] s;
		s = {1'b0, a} + {1'b0, b};
		return s[15:0] + {15'd0, s[16]};
	endfunction

	task automatic check_eq(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected)
		begin
			$display("CHECK FAILED at %0t: %s actual %0h expected %0h",
				$time, name, actual, expected);
			$display("TESTBENCH FAILED");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	// Expected payload of n words plus trailer
	task automatic build_model(input int n, input logic [15:0] pkt);
		logic [31:0] w;
		logic [15:0] acc;
		exp_q.delete();
		acc = '0;
		for (int i = 0; i < n; i++)
		begin
			if (i == 0)
				w = M_HEAD0;
			else if (i == 1)
				w = {M_HEAD1, pkt};
			else
				for (int b = 0; b < 4; b++)
					w[8*b +: 8] = 8'(3 - b + 4 * (i - 2));   // 00010203 then +4 per byte
			acc = ones_add(ones_add(acc, w[31:16]), w[15:0]);
			exp_q.push_back({w, (i == 0), 1'b0});
		end
		exp_q.push_back({~acc, 16'h0000, 1'b0, 1'b1});
	endtask

	task automatic start_payload(input logic [15:0] n);
		@(posedge pll_62_5m_clk);
		start       <= 1'b1;
		payload_len <= n;
		@(posedge pll_62_5m_clk);
		start       <= 1'b0;
	endtask

	// Drive words into the rx ports, one per cycle
	task automatic replay(input logic [33:0] pkt[$]);
		foreach (pkt[i])
		begin
			@(posedge pll_62_5m_clk);
			rx_pa   <= 1'b1;
			rx_data <= pkt[i][33:2];
			rx_sop  <= pkt[i][1];
			rx_eop  <= pkt[i][0];
		end
		@(posedge pll_62_5m_clk);
		rx_pa  <= 1'b0;
		rx_sop <= 1'b0;
		rx_eop <= 1'b0;
		@(negedge pll_62_5m_clk);
		check_eq("act_led_o after receive", act_led, 1'b0);
	endtask

	//--------------------------------------------------------------------------
	// Directed tests
	//--------------------------------------------------------------------------
	task automatic test_reset_state();
		@(negedge pll_62_5m_clk);
		check_eq("tx_wr_o", tx_wr, 1'b0);
		check_eq("tx_sop_o", tx_sop, 1'b0);
		check_eq("tx_eop_o", tx_eop, 1'b0);
		check_eq("busy_o", busy, 1'b0);
		check_eq("act_led_o", act_led, 1'b1);
		check_eq("seq_err_led_o", seq_err_led, 1'b1);
		check_eq("chksum_err_led_o", chksum_err_led, 1'b1);
	endtask

	// One packet, optionally with random write-allowed
	task automatic run_packet(input int n, input logic [15:0] pkt, input logic toggle_wa);
		int base;
		base = tx_log_q.size();
		build_model(n, pkt);
		start_payload(16'(n));
		@(negedge pll_62_5m_clk);   // Start was taken at the last edge
		check_eq("busy_o after start", busy, 1'b1);
		while (tx_log_q.size() < base + n + 1)
		begin
			@(posedge pll_62_5m_clk);
			if (toggle_wa)
				tx_wa <= rand_bit();
		end
		tx_wa <= 1'b1;
		@(negedge pll_62_5m_clk);   // Cycle after eop
		check_eq("busy_o after eop", busy, 1'b0);
		check_eq("tx word count", tx_log_q.size(), base + n + 1);
		for (int i = 0; i <= n; i++)
		begin
			check_eq($sformatf("tx_data_o word %0d", i), tx_log_q[base+i][33:2], exp_q[i][33:2]);
			check_eq($sformatf("tx_sop_o word %0d", i), tx_log_q[base+i][1], exp_q[i][1]);
			check_eq($sformatf("tx_eop_o word %0d", i), tx_log_q[base+i][0], exp_q[i][0]);
		end
	endtask

	task automatic test_short_length();
		int base;
		base = tx_log_q.size();
		start_payload(16'd2);
		repeat (10)
		begin
			@(negedge pll_62_5m_clk);
			check_eq("busy_o on short start", busy, 1'b0);
			check_eq("tx_wr_o on short start", tx_wr, 1'b0);
		end
		check_eq("tx word count on short start", tx_log_q.size(), base);
	endtask

	task automatic test_loopback();
		replay(tx_log_q);           // Packets 0 and 1 as sent
		check_eq("seq_err_led_o", seq_err_led, 1'b1);
		check_eq("chksum_err_led_o", chksum_err_led, 1'b1);
		repeat (ACT_HOLD_CYCLES + 2)
			@(posedge pll_62_5m_clk);
		@(negedge pll_62_5m_clk);
		check_eq("act_led_o after hold", act_led, 1'b1);
	endtask

	task automatic test_corrupt();
		build_model(6, 16'd2);
		exp_q[3] = exp_q[3] ^ 34'h0_0000_0400;   // Flip one data bit
		replay(exp_q);
		check_eq("chksum_err_led_o on bad sum", chksum_err_led, 1'b0);
		check_eq("seq_err_led_o on bad sum", seq_err_led, 1'b1);
		build_model(6, 16'd4);                   // Number 3 skipped
		replay(exp_q);
		check_eq("seq_err_led_o on skipped number", seq_err_led, 1'b0);
		check_eq("chksum_err_led_o stays set", chksum_err_led, 1'b0);
	endtask

	initial
	begin
		pll_62_5m_clk = 1'b0;
		rst_n         = 1'b0;
		start         = 1'b0;
		payload_len   = '0;
		tx_wa         = 1'b1;
		rx_pa         = 1'b0;
		rx_data       = '0;
		rx_sop        = 1'b0;
		rx_eop        = 1'b0;
		repeat (RESET_CYCLES)
			@(posedge pll_62_5m_clk);
		rst_n <= 1'b1;

		test_reset_state();
		run_packet(6, 16'd0, 1'b0);
		run_packet(12, 16'd1, 1'b1);   // Larger than the FIFO
		test_short_length();
		test_loopback();
		test_corrupt();

		if (u_stream_test_top.u_props.fail_count == 0)
		begin
			$display("TESTBENCH PASSED");
			$finish;
		end
		else
		begin
			$display("TESTBENCH FAILED");
			$fatal(1, "%0d assertion failures", u_stream_test_top.u_props.fail_count);
		end
	end

endmodule

`default_nettype wire

/* files.f */
src/stream_test_pkg.sv
src/word_push_if.sv
src/word_fifo.sv
src/payload_gen.sv
src/tx_framer.sv
src/rx_checker.sv
src/stream_test_top.sv
tests/stream_test_properties.sv
tests/stream_test_tb.sv
